// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ftp_inspect_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test target: success"; \
	else \
		echo "test target: failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
rtl/ftp_inspect_pkg.sv
rtl/keyword_dfa.sv
rtl/stream_match_counter.sv
rtl/packet_verdict.sv
rtl/ftp_inspect_top.sv
tests/clk_gen.sv
tests/ftp_inspect_tb.sv

// File: rtl/ftp_inspect_pkg.sv
package ftp_inspect_pkg;

   // Stream id width, 64 interleaved streams
   localparam int STREAM_W = 6;

   // DFA state holds the matched prefix length 0 to 8
   localparam int DFA_STATE_W = 4;

   // Width of the packet counters
   localparam int COUNT_W = 16;

   // One payload character with its valid strobe
   typedef struct packed
   {
      logic       vld;
      logic [7:0] data;
   } char_beat_t;

   // Packet start control, stable from load_state through eop
   typedef struct packed
   {
      logic [STREAM_W-1:0] stream_id;
      // Start the DFAs from state zero
      logic                new_stream;
      // Bit 0 enables USER, bit 1 enables PASS
      logic [1:0]          enable;
   } pkt_ctrl_t;

   // Packet verdict encoding
   typedef enum logic [1:0]
   {
      V_NONE  = 2'd0,
      V_USER  = 2'd1,
      V_PASS  = 2'd2,
      V_LOGIN = 2'd3
   } verdict_e;

   // One cycle verdict pulse
   typedef struct packed
   {
      logic     vld;
      verdict_e kind;
   } verdict_t;

endpackage

// File: rtl/ftp_inspect_top.sv
`timescale 1ns/100ps

module ftp_inspect_top
#(
   parameter logic [63:0] USER_PATTERN = {"USER", 32'd0},
   parameter logic [63:0] PASS_PATTERN = {"PASS", 32'd0},
   parameter int          PAT_LEN      = 4
)
(
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                load_state,
   input  ftp_inspect_pkg::pkt_ctrl_t          ctrl,
   input  ftp_inspect_pkg::char_beat_t         chr,
   input  logic                                eop,
   output logic [ftp_inspect_pkg::COUNT_W-1:0] user_count,
   output logic [ftp_inspect_pkg::COUNT_W-1:0] pass_count,
   output logic [ftp_inspect_pkg::COUNT_W-1:0] login_count,
   output ftp_inspect_pkg::verdict_t           verdict
);

   import ftp_inspect_pkg::*;

   // Per packet fired levels
   logic user_fired;
   logic pass_fired;

   // USER command matcher on enable bit 0
   stream_match_counter
   #(
      .PATTERN (USER_PATTERN),
      .PAT_LEN (PAT_LEN)
   )
   user_match_i
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .eop        (eop),
      .stream_id  (ctrl.stream_id),
      .new_stream (ctrl.new_stream),
      .enable     (ctrl.enable[0]),
      .chr        (chr),
      .fired      (user_fired),
      .count      (user_count)
   );

   // PASS command matcher on enable bit 1
   stream_match_counter
   #(
      .PATTERN (PASS_PATTERN),
      .PAT_LEN (PAT_LEN)
   )
   pass_match_i
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .eop        (eop),
      .stream_id  (ctrl.stream_id),
      .new_stream (ctrl.new_stream),
      .enable     (ctrl.enable[1]),
      .chr        (chr),
      .fired      (pass_fired),
      .count      (pass_count)
   );

   // Combine both flags into the packet verdict
   packet_verdict packet_verdict_i
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .eop         (eop),
      .user_fired  (user_fired),
      .pass_fired  (pass_fired),
      .enable      (ctrl.enable),
      .verdict     (verdict),
      .login_count (login_count)
   );

endmodule

// File: rtl/keyword_dfa.sv
`timescale 1ns/100ps

module keyword_dfa
#(
   parameter logic [63:0] PATTERN = {"USER", 32'd0},
   parameter int          PAT_LEN = 4
)
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  ftp_inspect_pkg::char_beat_t          chr,
   input  logic [ftp_inspect_pkg::DFA_STATE_W-1:0] state_in,
   input  logic                                 state_in_vld,
   output logic [ftp_inspect_pkg::DFA_STATE_W-1:0] state_out,
   output logic                                 accept
);

   import ftp_inspect_pkg::*;

   // Keyword split into bytes, first character at index 0
   logic [7:0]             pat_byte [0:7];

   // Matched prefix length
   logic [DFA_STATE_W-1:0] state;
   logic [DFA_STATE_W-1:0] next_state;

   // Byte the DFA expects next
   logic [7:0]             exp_byte;

   // Full keyword seen on this character
   logic                   hit;

   always_comb
   begin
      for (int i = 0; i < 8; i++)
      begin
         pat_byte[i] = PATTERN[63 - 8*i -: 8];
      end
   end

   // State never reaches 8 outside a restart, so the low bits index the keyword
   assign exp_byte = pat_byte[state[2:0]];

   // Prefix advance with restart on the first keyword byte
   always_comb
   begin
      next_state = state;
      hit        = 1'b0;
      if (chr.vld)
      begin
         if (chr.data == exp_byte)
         begin
            if (state == DFA_STATE_W'(PAT_LEN - 1))
            begin
               // Keyword complete, start over
               next_state = '0;
               hit        = 1'b1;
            end
            else
            begin
               next_state = state + 1'b1;
            end
         end
         else if (chr.data == pat_byte[0])
         begin
            // Mismatch that may begin a new keyword
            next_state = DFA_STATE_W'(1);
         end
         else
         begin
            next_state = '0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= '0;
         accept <= 1'b0;
      end
      else
      begin
         accept <= hit;
         // External load wins over character processing
         if (state_in_vld)
            state <= state_in;
         else
            state <= next_state;
      end
   end

   assign state_out = state;

   // Prefix length stays within the keyword
   a_state_range : assert property (@(posedge clk) disable iff (!rst_n)
      state <= DFA_STATE_W'(PAT_LEN));

endmodule

// File: rtl/packet_verdict.sv
`timescale 1ns/100ps

module packet_verdict
(
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                eop,
   input  logic                                user_fired,
   input  logic                                pass_fired,
   input  logic [1:0]                          enable,
   output ftp_inspect_pkg::verdict_t           verdict,
   output logic [ftp_inspect_pkg::COUNT_W-1:0] login_count
);

   import ftp_inspect_pkg::*;

   // Fired flags gated by their matcher enables
   logic     user_hit;
   logic     pass_hit;

   // Verdict for the packet ending now
   verdict_e kind;

   assign user_hit = user_fired && enable[0];
   assign pass_hit = pass_fired && enable[1];

   always_comb
   begin
      if (user_hit && pass_hit)
         kind = V_LOGIN;
      else if (user_hit)
         kind = V_USER;
      else if (pass_hit)
         kind = V_PASS;
      else
         kind = V_NONE;
   end

   // Verdict pulse one cycle after eop
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         verdict.vld  <= 1'b0;
         verdict.kind <= V_NONE;
         login_count  <= '0;
      end
      else
      begin
         verdict.vld <= eop;
         if (eop)
         begin
            verdict.kind <= kind;
            // Both keywords in one packet count as a login
            if (kind == V_LOGIN)
               login_count <= login_count + 1'b1;
         end
      end
   end

   // One pulse per packet
   a_single_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      verdict.vld |=> !verdict.vld);

endmodule

// File: rtl/stream_match_counter.sv
`timescale 1ns/100ps

module stream_match_counter
#(
   parameter logic [63:0] PATTERN = {"USER", 32'd0},
   parameter int          PAT_LEN = 4
)
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 load_state,
   input  logic                                 eop,
   input  logic [ftp_inspect_pkg::STREAM_W-1:0] stream_id,
   input  logic                                 new_stream,
   input  logic                                 enable,
   input  ftp_inspect_pkg::char_beat_t          chr,
   output logic                                 fired,
   output logic [ftp_inspect_pkg::COUNT_W-1:0]  count
);

   import ftp_inspect_pkg::*;

   localparam int STREAMS = 1 << STREAM_W;

   // Saved DFA state per stream
   logic [DFA_STATE_W-1:0] state_mem [0:STREAMS-1];

   // State handed to the DFA one cycle after load_state
   logic [DFA_STATE_W-1:0] state_in;
   logic                   state_in_vld;

   // DFA outputs
   logic [DFA_STATE_W-1:0] state_out;
   logic                   accept;

   // Restore path
   // New stream starts from zero, otherwise pick up the saved state
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream)
            state_in <= '0;
         else
            state_in <= state_mem[stream_id];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // Save path
   // Only an enabled packet moves the stream state forward
   always_ff @(posedge clk)
   begin
      if (eop && enable)
         state_mem[stream_id] <= state_out;
   end

   // Speculative fired flag and match count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired <= 1'b0;
         count <= '0;
      end
      else
      begin
         // Fresh packet, forget previous matches
         if (load_state)
            fired <= 1'b0;
         else if (accept)
            fired <= 1'b1;

         if (eop)
         begin
            if (enable)
               // Commit at most one match per packet
               count <= count + COUNT_W'(fired);
            else
               // Disabled matcher reports nothing
               fired <= 1'b0;
         end
      end
   end

   keyword_dfa
   #(
      .PATTERN (PATTERN),
      .PAT_LEN (PAT_LEN)
   )
   keyword_dfa_i
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .chr          (chr),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

   // Packet start and end are separate cycles
   a_load_eop_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(load_state && eop));

   // Restore must land in the DFA before the first character
   a_load_gap : assert property (@(posedge clk) disable iff (!rst_n)
      load_state |=> !chr.vld ##1 !chr.vld);

endmodule

// File: tests/clk_gen.sv
`timescale 1ns/100ps

module clk_gen
#(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 5
)
(
   output logic clk,
   output logic rst_n
);

   // Free running clock
   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset held low over the first rising edges, released on a falling edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: tests/ftp_inspect_tb.sv
`timescale 1ns/100ps

module ftp_inspect_tb;

   import ftp_inspect_pkg::*;

   localparam int NUM_PKTS = 17;
   localparam int KW_LEN   = 4;
   localparam int MAX_WAIT = 20;

   // One packet of stimulus with its expected verdict
   typedef struct packed
   {
      logic [STREAM_W-1:0] stream_id;
      logic                new_stream;
      logic [1:0]          enable;
      // First character in the top byte
      logic [127:0]        payload;
      logic [4:0]          len;
      // Random idle cycles between characters
      logic                gap;
      verdict_e            exp_kind;
   } pkt_entry_t;

   logic               clk;
   logic               rst_n;
   logic               load_state;
   pkt_ctrl_t          ctrl;
   char_beat_t         chr;
   logic               eop;
   logic [COUNT_W-1:0] user_count;
   logic [COUNT_W-1:0] pass_count;
   logic [COUNT_W-1:0] login_count;
   verdict_t           verdict;

   pkt_entry_t         pkt_table [0:NUM_PKTS-1];
   integer             seed;

   // Reference model state with USER at index 0 and PASS at index 1
   logic [31:0]        keyword [0:1];
   int                 saved_prefix [0:1][0:(1<<STREAM_W)-1];
   logic [COUNT_W-1:0] exp_count [0:1];
   logic [COUNT_W-1:0] exp_login_count;

   clk_gen #(.PERIOD(40), .RESET_CYCLES(5)) clk_gen_i (.clk(clk), .rst_n(rst_n));

   ftp_inspect_top
   #(
      .USER_PATTERN ({"USER", 32'd0}),
      .PASS_PATTERN ({"PASS", 32'd0}),
      .PAT_LEN      (KW_LEN)
   )
   ftp_inspect_top_i
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_state  (load_state),
      .ctrl        (ctrl),
      .chr         (chr),
      .eop         (eop),
      .user_count  (user_count),
      .pass_count  (pass_count),
      .login_count (login_count),
      .verdict     (verdict)
   );

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_verdict(input string name, input verdict_t got, input verdict_t exp);
      if (got !== exp)
         stop_with_failure($sformatf(
            "error at %0t: %s is vld=%0b kind=%0d, expected vld=%0b kind=%0d",
            $time, name, got.vld, got.kind, exp.vld, exp.kind));
   endtask

   task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                              input logic [COUNT_W-1:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("error at %0t: %s is %0d, expected %0d",
            $time, name, got, exp));
   endtask

   // Step to the next falling edge where no verdict may show up yet
   task automatic next_cycle;
      @(negedge clk);
      if (verdict.vld !== 1'b0)
         stop_with_failure($sformatf("Verdict pulse before end of packet at time %0t", $time));
   endtask

   task automatic wait_reset_release;
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1)
      begin
         if (cycles == MAX_WAIT)
            stop_with_failure("Reset was never released");
         @(negedge clk);
         cycles++;
      end
   endtask

   // Drop eop and wait for the verdict pulse
   task automatic wait_verdict;
      int cycles;
      cycles = 0;
      @(negedge clk);
      eop = 1'b0;
      while (verdict.vld !== 1'b1)
      begin
         if (cycles == MAX_WAIT)
            stop_with_failure("No verdict pulse after end of packet");
         @(negedge clk);
         cycles++;
      end
   endtask

   function automatic logic [7:0] kw_byte(input logic [31:0] kw, input int idx);
      return kw[31 - 8*idx -: 8];
   endfunction

   function automatic logic keyword_hit(input logic [31:0] kw, input int prefix,
                                        input logic [7:0] ch);
      return (ch == kw_byte(kw, prefix)) && (prefix == KW_LEN - 1);
   endfunction

   // A mismatch on the first keyword byte opens a new match
   function automatic int next_prefix(input logic [31:0] kw, input int prefix,
                                      input logic [7:0] ch);
      if (ch == kw_byte(kw, prefix))
         return (prefix == KW_LEN - 1) ? 0 : prefix + 1;
      else if (ch == kw_byte(kw, 0))
         return 1;
      else
         return 0;
   endfunction

   // Runs one packet through the model and updates the expected counts
   task automatic model_packet(input pkt_entry_t p, output verdict_e kind);
      int         prefix;
      logic [7:0] ch;
      logic       fired;
      logic [1:0] hit;
      hit = 2'b00;
      for (int m = 0; m < 2; m++)
      begin
         prefix = p.new_stream ? 0 : saved_prefix[m][p.stream_id];
         fired  = 1'b0;
         for (int i = 0; i < int'(p.len); i++)
         begin
            ch = p.payload[127 - 8*i -: 8];
            if (keyword_hit(keyword[m], prefix, ch))
               fired = 1'b1;
            prefix = next_prefix(keyword[m], prefix, ch);
         end
         // Disabled matcher neither counts nor saves
         if (p.enable[m])
         begin
            saved_prefix[m][p.stream_id] = prefix;
            exp_count[m] = exp_count[m] + COUNT_W'(fired);
            hit[m] = fired;
         end
      end
      case (hit)
         2'b11: kind = V_LOGIN;
         2'b01: kind = V_USER;
         2'b10: kind = V_PASS;
         default: kind = V_NONE;
      endcase
      if (kind == V_LOGIN)
         exp_login_count = exp_login_count + COUNT_W'(1);
   endtask

   function automatic pkt_entry_t make_pkt(input int sid, input logic ns,
                                           input logic [1:0] en, input string text,
                                           input logic gap, input verdict_e kind);
      pkt_entry_t p;
      p           = '0;
      p.stream_id = STREAM_W'(sid);
      p.new_stream = ns;
      p.enable    = en;
      p.gap       = gap;
      p.exp_kind  = kind;
      p.len       = 5'(text.len());
      for (int i = 0; i < text.len(); i++)
         p.payload[127 - 8*i -: 8] = text[i];
      return p;
   endfunction

   task automatic fill_table;
      // Whole keywords in fresh and continued streams
      pkt_table[0]  = make_pkt(3, 1'b1, 2'b11, "xUSERyz", 1'b0, V_USER);
      pkt_table[1]  = make_pkt(3, 1'b0, 2'b11, "USER PASS", 1'b1, V_LOGIN);
      // USER split across packets with restore and then with reset
      pkt_table[2]  = make_pkt(5, 1'b1, 2'b11, "abcUS", 1'b0, V_NONE);
      pkt_table[3]  = make_pkt(5, 1'b0, 2'b11, "ER ok", 1'b1, V_USER);
      pkt_table[4]  = make_pkt(7, 1'b1, 2'b11, "cmd US", 1'b0, V_NONE);
      pkt_table[5]  = make_pkt(7, 1'b1, 2'b11, "ER", 1'b0, V_NONE);
      // PASS halves in two interleaved streams
      pkt_table[6]  = make_pkt(10, 1'b1, 2'b11, "PA", 1'b0, V_NONE);
      pkt_table[7]  = make_pkt(20, 1'b1, 2'b11, "xxPA", 1'b0, V_NONE);
      pkt_table[8]  = make_pkt(10, 1'b0, 2'b11, "SS", 1'b0, V_PASS);
      pkt_table[9]  = make_pkt(20, 1'b0, 2'b11, "S", 1'b0, V_NONE);
      pkt_table[10] = make_pkt(20, 1'b0, 2'b11, "S\015\n", 1'b1, V_PASS);
      // Disabled USER matcher keeps the older saved state
      pkt_table[11] = make_pkt(33, 1'b1, 2'b11, "USE", 1'b0, V_NONE);
      pkt_table[12] = make_pkt(33, 1'b0, 2'b10, "R PASS", 1'b1, V_PASS);
      pkt_table[13] = make_pkt(33, 1'b0, 2'b11, "R", 1'b0, V_USER);
      pkt_table[14] = make_pkt(40, 1'b1, 2'b01, "PASS USER", 1'b0, V_USER);
      pkt_table[15] = make_pkt(63, 1'b1, 2'b11, "PASSUSER", 1'b1, V_LOGIN);
      pkt_table[16] = make_pkt(0, 1'b1, 2'b00, "USERPASS", 1'b0, V_NONE);
   endtask

   task automatic check_counts;
      check_count("user_count", user_count, exp_count[0]);
      check_count("pass_count", pass_count, exp_count[1]);
      check_count("login_count", login_count, exp_login_count);
   endtask

   task automatic run_packet(input int n, input pkt_entry_t p);
      verdict_e model_kind;
      verdict_t exp_v;
      int       idle;
      model_packet(p, model_kind);
      if (model_kind != p.exp_kind)
         stop_with_failure($sformatf("Reference model and table disagree on packet %0d", n));
      next_cycle();
      ctrl.stream_id  = p.stream_id;
      ctrl.new_stream = p.new_stream;
      ctrl.enable     = p.enable;
      load_state      = 1'b1;
      // Two quiet cycles while the saved state reaches the DFA
      next_cycle();
      load_state = 1'b0;
      next_cycle();
      for (int i = 0; i < int'(p.len); i++)
      begin
         if (p.gap && i > 0)
         begin
            idle = {$random(seed)} % 4;
            repeat (idle)
            begin
               next_cycle();
               chr = '0;
            end
         end
         next_cycle();
         chr.vld  = 1'b1;
         chr.data = p.payload[127 - 8*i -: 8];
      end
      // Accept and fired settle before eop
      next_cycle();
      chr = '0;
      next_cycle();
      next_cycle();
      eop = 1'b1;
      wait_verdict();
      exp_v.vld  = 1'b1;
      exp_v.kind = p.exp_kind;
      check_verdict("verdict", verdict, exp_v);
      check_counts();
   endtask

   initial
   begin
      seed            = 20;
      load_state      = 1'b0;
      ctrl            = '0;
      chr             = '0;
      eop             = 1'b0;
      keyword[0]      = "USER";
      keyword[1]      = "PASS";
      exp_count[0]    = '0;
      exp_count[1]    = '0;
      exp_login_count = '0;
      for (int m = 0; m < 2; m++)
         for (int s = 0; s < (1 << STREAM_W); s++)
            saved_prefix[m][s] = 0;
      fill_table();
      wait_reset_release();
      // Quiet outputs and zero counts right after reset
      repeat (3) next_cycle();
      check_counts();
      for (int n = 0; n < NUM_PKTS; n++)
         run_packet(n, pkt_table[n]);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
